// ==== hdl/dlc_cfg_pkg.sv ====
// Sample, level and configuration widths for the level-crossing datapath
// Imported by the FIFO wiring, the quantizer, the encoder and the top level
package dlc_cfg_pkg;

  // Raw input sample width
  localparam int unsigned SAMPLE_W = 16;

  // Width of the level-width exponent, levels are 2**log_wl samples wide
  localparam int unsigned LOG_WL_W = 4;  // Exponents 0 to 15

  // Signed sample or level value
  typedef logic signed [SAMPLE_W-1:0] sample_t;

endpackage

// ==== hdl/dlc_pkt_pkg.sv ====
// Output packet layout of the level-crossing encoder
// Delta-time field on top, level field below, read in one of two formats
package dlc_pkt_pkg;

  localparam int unsigned DT_W        = 10;  // Delta-time field
  localparam int unsigned LVL_FIELD_W = 6;   // Level field

  // Largest delta time that fits the field
  localparam int unsigned DT_MAX = (1 << DT_W) - 1;

  // Largest step per packet, same in both formats
  localparam int unsigned MAG_MAX = (1 << (LVL_FIELD_W - 1)) - 1;

  // One packet word, level field decoded by the format select
  typedef union packed {
    // Two's-complement step
    struct packed {
      logic [DT_W-1:0]               dt;
      logic signed [LVL_FIELD_W-1:0] step;  // Negative when level fell
    } twos;
    // Direction bit plus magnitude
    struct packed {
      logic [DT_W-1:0]          dt;
      logic                     dir;   // 1 = downward
      logic [LVL_FIELD_W-2:0]   mag;
    } sgnmag;
  } dlc_word_u;

endpackage

// ==== hdl/dlc_sample_fifo.sv ====
// Synchronous circular-buffer FIFO, head word shown while not empty
// Used for input samples and for output packets
`timescale 1ns/1ns

module dlc_sample_fifo #(
  parameter int unsigned FIFO_DEPTH = 4,
  parameter int unsigned DATA_W     = 16
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  logic [DATA_W-1:0] data_i,
  input  logic              pop_i,
  output logic [DATA_W-1:0] data_o,
  output logic              full_o,
  output logic              empty_o
);

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [DATA_W-1:0] mem_q [FIFO_DEPTH];  // Storage, no reset
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;               // Occupancy
  logic              do_push, do_pop;

  assign full_o  = (cnt_q == CNT_W'(FIFO_DEPTH));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];  // Head word, valid when not empty

  // Illegal requests dropped here
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        // Wrap for any depth, not only powers of two
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) cnt_q <= cnt_q + 1'b1;
      else if (do_pop && !do_push) cnt_q <= cnt_q - 1'b1;
    end
  end

endmodule

// ==== hdl/dlc_quantizer.sv ====
// Level detection and crossing generation for the head sample of the input FIFO
// Pops one sample per cycle while the encoder is not busy
`timescale 1ns/1ns

module dlc_quantizer (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  dlc_cfg_pkg::sample_t               head_i,
  input  logic                               empty_i,
  input  logic                               busy_i,
  input  logic [dlc_cfg_pkg::LOG_WL_W-1:0]   log_wl_i,
  output logic                               pop_o,
  output logic                               smp_vld_o,
  output logic                               smp_xing_o,
  output logic                               smp_dir_o,
  output logic [dlc_cfg_pkg::SAMPLE_W-1:0]   smp_mag_o,
  output logic                               xing_o,
  output logic                               dir_o
);

  import dlc_cfg_pkg::*;

  sample_t             lvl;        // Level of head sample
  sample_t             cur_lvl_q;  // Level of last crossing
  logic signed [SAMPLE_W:0] dlvl;  // One extra bit, full range difference
  logic [SAMPLE_W:0]   dlvl_abs;
  logic                dir_q;

  // Arithmetic shift keeps negative samples on negative levels
  assign lvl = head_i >>> log_wl_i;

  always_comb begin
    dlvl     = $signed({lvl[SAMPLE_W-1], lvl}) - $signed({cur_lvl_q[SAMPLE_W-1], cur_lvl_q});
    dlvl_abs = dlvl[SAMPLE_W] ? -dlvl : dlvl;  // At most 65535
  end

  // Take a sample whenever one waits and the encoder can accept it
  assign pop_o      = ~empty_i & ~busy_i;
  assign smp_vld_o  = pop_o;
  assign smp_xing_o = pop_o & (dlvl != '0);
  assign smp_dir_o  = dlvl[SAMPLE_W];       // 1 = level fell
  assign smp_mag_o  = dlvl_abs[SAMPLE_W-1:0];

  assign xing_o = smp_xing_o;  // One pulse per accepted crossing
  assign dir_o  = dir_q;

  // Level and direction follow each crossing
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cur_lvl_q <= '0;
      dir_q     <= 1'b0;
    end else if (smp_xing_o) begin
      cur_lvl_q <= lvl;
      dir_q     <= smp_dir_o;
    end
  end

endmodule

// ==== hdl/dlc_event_encoder.sv ====
// Delta-time counting and packet assembly, one packet per crossing
// Large steps are split into bursts, long quiet runs give overflow packets
`timescale 1ns/1ns

module dlc_event_encoder (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              smp_vld_i,
  input  logic                              smp_xing_i,
  input  logic                              smp_dir_i,
  input  logic [dlc_cfg_pkg::SAMPLE_W-1:0]  smp_mag_i,
  input  logic                              fmt_twos_i,
  input  logic                              full_i,
  output logic                              busy_o,
  output logic                              push_o,
  output dlc_pkt_pkg::dlc_word_u            word_o
);

  import dlc_cfg_pkg::*;
  import dlc_pkt_pkg::*;

  localparam int unsigned MAG_W = LVL_FIELD_W - 1;

  typedef enum logic {
    ST_RUN,
    ST_SPLIT  // Burst of zero-time packets
  } state_t;

  state_t              state_q, state_d;
  logic [DT_W-1:0]     cnt_q, cnt_d;    // Samples since last crossing
  logic [SAMPLE_W-1:0] rem_q, rem_d;    // Step still to send in burst
  logic                rdir_q, rdir_d;  // Burst direction
  logic [DT_W-1:0]     pkt_dt;
  logic [MAG_W-1:0]    pkt_mag;
  logic                pkt_dir;

  // Split state stalls sampling, as does a full output FIFO
  assign busy_o = (state_q == ST_SPLIT) | full_i;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    rem_d   = rem_q;
    rdir_d  = rdir_q;
    push_o  = 1'b0;
    pkt_dt  = '0;
    pkt_mag = '0;
    pkt_dir = 1'b0;
    case (state_q)
      ST_RUN: begin
        if (smp_vld_i && smp_xing_i) begin
          push_o  = 1'b1;  // Room guaranteed, sample only taken when not busy
          pkt_dt  = cnt_q;
          pkt_dir = smp_dir_i;
          cnt_d   = DT_W'(1);
          if (smp_mag_i > SAMPLE_W'(MAG_MAX)) begin
            pkt_mag = MAG_W'(MAG_MAX);  // First of burst
            rem_d   = smp_mag_i - SAMPLE_W'(MAG_MAX);
            rdir_d  = smp_dir_i;
            state_d = ST_SPLIT;
          end else begin
            pkt_mag = smp_mag_i[MAG_W-1:0];
          end
        end else if (smp_vld_i) begin
          if (cnt_q == DT_W'(DT_MAX)) begin
            push_o = 1'b1;  // Time overflow, level field stays zero
            pkt_dt = DT_W'(DT_MAX);
            cnt_d  = DT_W'(1);
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end
      ST_SPLIT: begin
        pkt_dir = rdir_q;
        if (!full_i) begin
          push_o = 1'b1;
          if (rem_q > SAMPLE_W'(MAG_MAX)) begin
            pkt_mag = MAG_W'(MAG_MAX);
            rem_d   = rem_q - SAMPLE_W'(MAG_MAX);
          end else begin
            pkt_mag = rem_q[MAG_W-1:0];  // Last of burst
            state_d = ST_RUN;
          end
        end
      end
      default: state_d = ST_RUN;
    endcase
  end

  // Level field in the selected format
  always_comb begin
    if (fmt_twos_i) begin
      word_o.twos.dt   = pkt_dt;
      word_o.twos.step = pkt_dir ? -$signed({1'b0, pkt_mag}) : $signed({1'b0, pkt_mag});
    end else begin
      word_o.sgnmag.dt  = pkt_dt;
      word_o.sgnmag.dir = pkt_dir;
      word_o.sgnmag.mag = pkt_mag;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_RUN;
      cnt_q   <= DT_W'(1);  // Reset counts as a crossing at sample 0
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Burst payload
  always_ff @(posedge clk_i) begin
    rem_q  <= rem_d;
    rdir_q <= rdir_d;
  end

endmodule

// ==== hdl/dlc_top.sv ====
// Level-crossing encoder top, input FIFO to quantizer to encoder to output FIFO
// Samples pushed with in_push_i, packets read with out_pop_i
`timescale 1ns/1ns

module dlc_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic [dlc_cfg_pkg::LOG_WL_W-1:0]              log_wl_i,
  input  logic                                          fmt_twos_i,  // 1 = two's complement
  input  dlc_cfg_pkg::sample_t                          in_data_i,
  input  logic                                          in_push_i,
  input  logic                                          out_pop_i,
  output logic                                          in_full_o,
  output logic [$bits(dlc_pkt_pkg::dlc_word_u)-1:0]     out_data_o,
  output logic                                          out_empty_o,
  output logic                                          xing_o,
  output logic                                          dir_o
);

  import dlc_cfg_pkg::*;
  import dlc_pkt_pkg::*;

  sample_t             in_head;
  logic                in_empty, in_pop;
  logic                smp_vld, smp_xing, smp_dir;
  logic [SAMPLE_W-1:0] smp_mag;
  logic                enc_busy, enc_push, out_full;
  dlc_word_u           enc_word;

  dlc_sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .DATA_W(SAMPLE_W)) u_in_fifo (
    .clk_i, .rst_ni,
    .push_i (in_push_i), .data_i (in_data_i), .pop_i (in_pop),
    .data_o (in_head), .full_o (in_full_o), .empty_o (in_empty)
  );

  dlc_quantizer u_quantizer (
    .clk_i, .rst_ni,
    .head_i (in_head), .empty_i (in_empty), .busy_i (enc_busy), .log_wl_i,
    .pop_o (in_pop), .smp_vld_o (smp_vld), .smp_xing_o (smp_xing),
    .smp_dir_o (smp_dir), .smp_mag_o (smp_mag), .xing_o, .dir_o
  );

  dlc_event_encoder u_encoder (
    .clk_i, .rst_ni,
    .smp_vld_i (smp_vld), .smp_xing_i (smp_xing), .smp_dir_i (smp_dir),
    .smp_mag_i (smp_mag), .fmt_twos_i, .full_i (out_full),
    .busy_o (enc_busy), .push_o (enc_push), .word_o (enc_word)
  );

  // Packet queue, drained by the consumer
  dlc_sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .DATA_W($bits(dlc_word_u))) u_out_fifo (
    .clk_i, .rst_ni,
    .push_i (enc_push), .data_i (enc_word), .pop_i (out_pop_i),
    .data_o (out_data_o), .full_o (out_full), .empty_o (out_empty_o)
  );

endmodule

// ==== verification/dlc_scoreboard.sv ====
// Reference model and output checker for the level-crossing encoder
// Watches the top-level ports, queues expected packets and flags the first mismatch
`timescale 1ns/1ns

module dlc_scoreboard (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [dlc_cfg_pkg::LOG_WL_W-1:0]          log_wl_i,
  input  logic                                      fmt_twos_i,
  input  dlc_cfg_pkg::sample_t                      in_data_i,
  input  logic                                      in_push_i,
  input  logic                                      in_full_i,
  input  logic                                      out_pop_i,
  input  logic [$bits(dlc_pkt_pkg::dlc_word_u)-1:0] out_data_i,
  input  logic                                      out_empty_i,
  input  logic                                      xing_i,
  output logic                                      err_o,
  output int unsigned                               pending_o,
  output int unsigned                               exp_xing_o,
  output int unsigned                               seen_xing_o,
  output logic                                      exp_dir_o
);

  import dlc_cfg_pkg::*;
  import dlc_pkt_pkg::*;

  localparam int unsigned MAG_W = LVL_FIELD_W - 1;

  dlc_word_u   exp_q[$];  // Expected packets, oldest first
  dlc_word_u   exp_head;  // Oldest expected packet
  int          cur_lvl;   // Level of last modeled crossing
  int unsigned dt_cnt;    // Samples since last crossing

  initial err_o = 1'b0;

  // Packet word from delta time, magnitude and direction
  function automatic dlc_word_u make_word(input int unsigned dt, input int unsigned mag,
                                          input logic dir, input logic twos);
    dlc_word_u w;
    int        step;
    w    = '0;
    step = dir ? -int'(mag) : int'(mag);  // Downward steps negative
    if (twos) begin
      w.twos.dt   = DT_W'(dt);
      w.twos.step = LVL_FIELD_W'(step);
    end else begin
      w.sgnmag.dt  = DT_W'(dt);
      w.sgnmag.dir = dir;
      w.sgnmag.mag = MAG_W'(mag);
    end
    return w;
  endfunction

  // Quantize, count and split one accepted sample
  task automatic model_sample(input sample_t s);
    int          lvl;
    int          diff;
    int unsigned rem;
    logic        dir;
    lvl  = int'(s) >>> log_wl_i;
    diff = lvl - cur_lvl;
    if (diff != 0) begin
      dir = (diff < 0);
      rem = (diff < 0) ? -diff : diff;
      exp_q.push_back(make_word(dt_cnt, (rem > MAG_MAX) ? MAG_MAX : rem, dir, fmt_twos_i));
      rem = (rem > MAG_MAX) ? rem - MAG_MAX : 0;
      while (rem > 0) begin  // Burst tail, zero delta time
        exp_q.push_back(make_word(0, (rem > MAG_MAX) ? MAG_MAX : rem, dir, fmt_twos_i));
        rem = (rem > MAG_MAX) ? rem - MAG_MAX : 0;
      end
      cur_lvl    = lvl;
      dt_cnt     = 1;
      exp_xing_o = exp_xing_o + 1;
      exp_dir_o  = dir;
    end else if (dt_cnt == DT_MAX) begin
      exp_q.push_back(make_word(DT_MAX, 0, 1'b0, fmt_twos_i));  // Time overflow
      dt_cnt = 1;
    end else begin
      dt_cnt = dt_cnt + 1;
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      exp_q.delete();
      cur_lvl     = 0;
      dt_cnt      = 1;  // Reset acts as a crossing
      exp_xing_o  = 0;
      seen_xing_o = 0;
      exp_dir_o   = 1'b0;
    end else begin
      if (out_pop_i && !out_empty_i && exp_q.size() > 0) void'(exp_q.pop_front());
      if (in_push_i && !in_full_i) model_sample(in_data_i);
      if (xing_i) seen_xing_o = seen_xing_o + 1;
    end
    exp_head  = (exp_q.size() > 0) ? exp_q[0] : '0;
    pending_o = exp_q.size();
  end

  // Each accepted pop must show the oldest expected packet
  property pop_matches_model;
    @(posedge clk_i) disable iff (!rst_ni)
      (out_pop_i && !out_empty_i) |-> (pending_o != 0 && out_data_i == exp_head);
  endproperty

  assert property (pop_matches_model)
    else begin
      $display("Error: %0t ns, packet %h popped, model expected %h (%0d pending)",
               $time, $sampled(out_data_i), $sampled(exp_head), $sampled(pending_o));
      err_o = 1'b1;
    end

endmodule

// ==== verification/tb_dlc_top.sv ====
// Testbench for the level-crossing encoder, drives the stimulus phases
// Packet checks run in the scoreboard, end-of-phase checks here
`timescale 1ns/1ns

module tb_dlc_top;

  import dlc_cfg_pkg::*;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam logic [31:0] SEED       = 32'h9fcb_a61d;
  localparam int unsigned FILL_MAX   = 4 * FIFO_DEPTH + 8;  // Back-pressure push limit
  localparam int unsigned N_SAMPLES  = 200 + 200 + 120 + 2201 + FILL_MAX;
  localparam int unsigned WDOG_NS    = 8 * N_SAMPLES * 20 + 40000;  // Drain margin on top

  logic                clk = 1'b0;
  logic                rst_n;
  logic [LOG_WL_W-1:0] log_wl;
  logic                fmt_twos;
  sample_t             in_data;
  logic                in_push, out_pop;
  logic                in_full, out_empty, xing, dir;
  logic [15:0]         out_data;
  logic                sb_err, sb_exp_dir;
  int unsigned         sb_pending, sb_exp_xing, sb_seen_xing;
  logic [31:0]         rng, pop_rng;
  int                  pop_mode;  // 0 hold low, 1 random, 2 always

  always #10 clk = ~clk;  // 20 ns period

  dlc_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_dlc_top (
    .clk_i (clk), .rst_ni (rst_n), .log_wl_i (log_wl), .fmt_twos_i (fmt_twos),
    .in_data_i (in_data), .in_push_i (in_push), .out_pop_i (out_pop),
    .in_full_o (in_full), .out_data_o (out_data), .out_empty_o (out_empty),
    .xing_o (xing), .dir_o (dir)
  );

  dlc_scoreboard u_scoreboard (
    .clk_i (clk), .rst_ni (rst_n), .log_wl_i (log_wl), .fmt_twos_i (fmt_twos),
    .in_data_i (in_data), .in_push_i (in_push), .in_full_i (in_full),
    .out_pop_i (out_pop), .out_data_i (out_data), .out_empty_i (out_empty),
    .xing_i (xing), .err_o (sb_err), .pending_o (sb_pending),
    .exp_xing_o (sb_exp_xing), .seen_xing_o (sb_seen_xing), .exp_dir_o (sb_exp_dir)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  // Called on a falling edge, returns one falling edge after the push
  task automatic push_sample(input sample_t s);
    while (in_full) @(negedge clk);  // Wait for room
    in_data = s;
    in_push = 1'b1;
    @(negedge clk);
    in_push = 1'b0;
  endtask

  task automatic check_idle_outputs();
    assert (out_empty && !in_full && !xing && !dir)
      else fail_run($sformatf("Error: %0t ns, idle outputs empty %b full %b xing %b dir %b",
                              $time, out_empty, in_full, xing, dir));
  endtask

  // Pop until the output stays empty, then every expected packet must be out
  task automatic drain_and_check();
    int unsigned quiet;
    pop_mode = 2;
    quiet    = 0;
    while (quiet < FIFO_DEPTH + 2) begin  // Long enough to clear the input FIFO
      @(negedge clk);
      quiet = out_empty ? quiet + 1 : 0;
    end
    assert (sb_pending == 0)
      else fail_run($sformatf("Error: %0t ns, %0d expected packets never arrived",
                              $time, sb_pending));
    assert (sb_seen_xing == sb_exp_xing && dir == sb_exp_dir)
      else fail_run($sformatf("Error: %0t ns, %0d crossings dir %b, model %0d dir %b",
                              $time, sb_seen_xing, dir, sb_exp_xing, sb_exp_dir));
  endtask

  always @(negedge clk) begin
    pop_rng = lcg_next(pop_rng);
    case (pop_mode)
      1:       out_pop = pop_rng[16];
      2:       out_pop = 1'b1;
      default: out_pop = 1'b0;
    endcase
  end

  always @(posedge sb_err) begin
    $display("Errors found");
    $fatal(1, "Scoreboard saw a packet mismatch");
  end

  initial begin
    #(WDOG_NS);
    fail_run("Watchdog expired, the run did not finish in time");
  end

  initial begin
    sample_t     walk;
    logic        up;
    int unsigned n;
    rst_n    = 1'b0;
    log_wl   = 4;
    fmt_twos = 1'b1;
    in_data  = '0;
    in_push  = 1'b0;
    out_pop  = 1'b0;
    pop_mode = 0;
    rng      = SEED;
    pop_rng  = ~SEED;  // Separate stream for pops
    repeat (2) @(negedge clk);
    check_idle_outputs();  // Inside reset
    repeat (6) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();

    // Two's-complement small steps
    pop_mode = 1;
    walk     = '0;
    repeat (200) begin
      rng  = lcg_next(rng);
      walk = walk + sample_t'(rng[22:16]) - sample_t'(64);
      push_sample(walk);
    end
    drain_and_check();

    fmt_twos = 1'b0;  // Sign-magnitude, same kind of walk
    pop_mode = 1;
    repeat (200) begin
      rng  = lcg_next(rng);
      walk = walk + sample_t'(rng[22:16]) - sample_t'(64);
      push_sample(walk);
    end
    drain_and_check();

    // Large jumps at unit level width, bursts
    log_wl   = 0;
    fmt_twos = 1'b1;
    pop_mode = 1;
    up       = 1'b0;
    repeat (40) begin
      rng  = lcg_next(rng);
      up   = ~up;
      walk = up ? sample_t'(rng[24:16]) + sample_t'(40) : -(sample_t'(rng[24:16]) + sample_t'(40));
      repeat (3) push_sample(walk);  // Jump plus two quiet samples
    end
    drain_and_check();

    // Long flat run, overflow packets then one crossing
    log_wl   = 2;
    pop_mode = 1;
    repeat (2200) push_sample(16'sd1000);
    push_sample(16'sd1040);
    drain_and_check();

    // No pops, fill both FIFOs
    pop_mode = 0;
    n        = 0;
    while (!in_full && n < FILL_MAX) begin
      push_sample(n[0] ? 16'sd40 : -16'sd40);
      n = n + 1;
    end
    assert (in_full)
      else fail_run("Input FIFO never became full while the output was blocked");
    drain_and_check();

    if (sb_err) begin
      $display("Errors found");
      $fatal(1);
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// ==== build.f ====
hdl/dlc_cfg_pkg.sv
hdl/dlc_pkt_pkg.sv
hdl/dlc_sample_fifo.sv
hdl/dlc_quantizer.sv
hdl/dlc_event_encoder.sv
hdl/dlc_top.sv
verification/dlc_scoreboard.sv
verification/tb_dlc_top.sv

// ==== Bender.yml ====
package:
  name: dlc_encoder

sources:
  # Packages first, then RTL bottom-up
  - hdl/dlc_cfg_pkg.sv
  - hdl/dlc_pkt_pkg.sv
  - hdl/dlc_sample_fifo.sv
  - hdl/dlc_quantizer.sv
  - hdl/dlc_event_encoder.sv
  - hdl/dlc_top.sv

  # Testbench, top module tb_dlc_top
  - target: simulation
    files:
      - verification/dlc_scoreboard.sv
      - verification/tb_dlc_top.sv
